// File: hw/hbridge_pkg.sv
// shared sizes, register map and bus structs for the four-bridge FET driver
// referenced by scoped names from every RTL file and the testbench
package hbridge_pkg;

  // bridge count and field widths
  localparam int num_bridges = 4;
  localparam int half_w = 16;
  localparam int dead_w = 8;

  // spi frame is rd + addr + data, msb first
  localparam int addr_w = 7;
  localparam int data_w = 16;
  localparam int frame_w = 1 + addr_w + data_w;
  // one spare bit so the counter can saturate past a full frame
  localparam int bit_cnt_w = $clog2(frame_w) + 1;

  // register map
  localparam logic [addr_w-1:0] addr_ctrl = 7'd0;
  // halves for bridges 0..3 sit at 1..4
  localparam logic [addr_w-1:0] addr_half0 = 7'd1;
  localparam logic [addr_w-1:0] addr_dead = 7'd5;
  // read-only, writing 1s clears fault latches
  localparam logic [addr_w-1:0] addr_status = 7'd6;
  localparam logic [addr_w-1:0] addr_id = 7'd7;

  localparam logic [data_w-1:0] id_value = 16'h4842;

  // 15 kHz at a 12 MHz clk
  localparam logic [half_w-1:0] reset_half = 16'd400;
  localparam logic [dead_w-1:0] reset_dead = 8'd6;

  // received spi frame, rd is the first bit on the wire
  typedef struct packed {
    logic rd;
    logic [addr_w-1:0] addr;
    logic [data_w-1:0] data;
  } spi_frame_t;

  // per-bridge configuration as seen by a driver
  typedef struct packed {
    logic enable;
    logic [half_w-1:0] half;
    logic [dead_w-1:0] dead;
  } bridge_cfg_t;

  // gate drives of one bridge, f1/f2 leg 1 and f3/f4 leg 2
  typedef struct packed {
    logic f1;
    logic f2;
    logic f3;
    logic f4;
  } fets_t;

  // the two drive patterns, 1001 and 0110
  localparam fets_t fets_drive_a = '{f1: 1'b1, f2: 1'b0, f3: 1'b0, f4: 1'b1};
  localparam fets_t fets_drive_b = '{f1: 1'b0, f2: 1'b1, f3: 1'b1, f4: 1'b0};

endpackage

// File: hw/spi_reg_slave.sv
// spi mode 0 register slave, pins oversampled in the clk domain
// holds enable, half period and dead time registers and serves id and status reads
module spi_reg_slave (
  input  logic clk,
  input  logic reset_n,
  input  logic sck,
  input  logic ss_n,
  input  logic sdi,
  output logic sdo,
  input  logic [hbridge_pkg::num_bridges-1:0] fault,
  output hbridge_pkg::bridge_cfg_t cfg [hbridge_pkg::num_bridges],
  output logic [hbridge_pkg::num_bridges-1:0] fault_clear
);

  // two sync flops plus one more for edge detect
  logic [2:0] sck_q;
  logic [2:0] ss_q;
  logic [1:0] sdi_q;
  logic sck_rise;
  logic sck_fall;
  logic ss_rise;
  logic ss_active;

  hbridge_pkg::spi_frame_t frame_q;
  logic [hbridge_pkg::bit_cnt_w-1:0] bit_cnt_q;
  logic [hbridge_pkg::data_w-1:0] tx_q;
  logic [hbridge_pkg::data_w-1:0] rd_data;
  logic [hbridge_pkg::addr_w-1:0] rd_addr;
  logic wr_commit;

  // configuration registers
  logic [hbridge_pkg::num_bridges-1:0] enable_q;
  logic [hbridge_pkg::num_bridges-1:0][hbridge_pkg::half_w-1:0] half_q;
  logic [hbridge_pkg::dead_w-1:0] dead_q;
  logic [hbridge_pkg::num_bridges-1:0] fault_clear_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      // idle levels, sck low and ss high
      sck_q <= 3'b000;
      ss_q <= 3'b111;
      sdi_q <= 2'b00;
    end
    else
    begin
      sck_q <= {sck_q[1:0], sck};
      ss_q <= {ss_q[1:0], ss_n};
      sdi_q <= {sdi_q[0], sdi};
    end
  end

  assign sck_rise = sck_q[1] & ~sck_q[2];
  assign sck_fall = ~sck_q[1] & sck_q[2];
  assign ss_rise = ss_q[1] & ~ss_q[2];
  assign ss_active = ~ss_q[1];

  // sdi_q[1] lines up with sck_q[1], both two flops late
  always_ff @(posedge clk)
  begin
    if (ss_active && sck_rise)
    begin
      frame_q <= {frame_q[hbridge_pkg::frame_w-2:0], sdi_q[1]};
    end
  end

  // bit count and read shifter, both cleared while deselected
  always_ff @(posedge clk)
  begin
    if (!reset_n || !ss_active)
    begin
      bit_cnt_q <= '0;
      tx_q <= '0;
    end
    else
    begin
      // saturate so an overlong frame never wraps back to 24
      if (sck_rise && bit_cnt_q != '1)
      begin
        bit_cnt_q <= bit_cnt_q + 1'b1;
      end
      if (sck_fall)
      begin
        // first fall after the address byte puts data msb on sdo
        if (bit_cnt_q == hbridge_pkg::bit_cnt_w'(hbridge_pkg::addr_w + 1))
        begin
          tx_q <= frame_q[hbridge_pkg::addr_w] ? rd_data : '0;
        end
        else
        begin
          tx_q <= {tx_q[hbridge_pkg::data_w-2:0], 1'b0};
        end
      end
    end
  end

  assign sdo = tx_q[hbridge_pkg::data_w-1] & ss_active;

  // after 8 bits the address sits in the low bits of the shifter
  assign rd_addr = frame_q[hbridge_pkg::addr_w-1:0];

  always_comb
  begin
    rd_data = '0;
    case (rd_addr)
      hbridge_pkg::addr_ctrl:
        rd_data = {{(hbridge_pkg::data_w - hbridge_pkg::num_bridges){1'b0}}, enable_q};
      hbridge_pkg::addr_dead:
        rd_data = {{(hbridge_pkg::data_w - hbridge_pkg::dead_w){1'b0}}, dead_q};
      hbridge_pkg::addr_status:
        // live enables over fault latches
        rd_data = {{(hbridge_pkg::data_w - 2 * hbridge_pkg::num_bridges){1'b0}},
                   enable_q, fault};
      hbridge_pkg::addr_id:
        rd_data = hbridge_pkg::id_value;
      default:
      begin
        for (int b = 0; b < hbridge_pkg::num_bridges; b++)
        begin
          if (rd_addr == hbridge_pkg::addr_w'(hbridge_pkg::addr_half0 + b))
          begin
            rd_data = half_q[b];
          end
        end
      end
    endcase
  end

  // writes land on ss rising, only for exactly 24 bits
  assign wr_commit = ss_rise && !frame_q.rd &&
                     bit_cnt_q == hbridge_pkg::bit_cnt_w'(hbridge_pkg::frame_w);

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      enable_q <= '0;
      half_q <= {hbridge_pkg::num_bridges{hbridge_pkg::reset_half}};
      dead_q <= hbridge_pkg::reset_dead;
      fault_clear_q <= '0;
    end
    else
    begin
      // clear pulse lasts one cycle
      fault_clear_q <= '0;
      if (wr_commit)
      begin
        case (frame_q.addr)
          hbridge_pkg::addr_ctrl:
            enable_q <= frame_q.data[hbridge_pkg::num_bridges-1:0];
          hbridge_pkg::addr_dead:
            dead_q <= frame_q.data[hbridge_pkg::dead_w-1:0];
          hbridge_pkg::addr_status:
            fault_clear_q <= frame_q.data[hbridge_pkg::num_bridges-1:0];
          default:
          begin
            // id and unmapped addresses match nothing here
            for (int b = 0; b < hbridge_pkg::num_bridges; b++)
            begin
              if (frame_q.addr == hbridge_pkg::addr_w'(hbridge_pkg::addr_half0 + b))
              begin
                half_q[b] <= frame_q.data[hbridge_pkg::half_w-1:0];
              end
            end
          end
        endcase
      end
    end
  end

  assign fault_clear = fault_clear_q;

  // a faulted bridge parks, so it restarts in drive A once cleared
  always_comb
  begin
    for (int b = 0; b < hbridge_pkg::num_bridges; b++)
    begin
      cfg[b].enable = enable_q[b] & ~fault[b];
      cfg[b].half = half_q[b];
      cfg[b].dead = dead_q;
    end
  end

  // register state and clear pulses only move right after ss rises
  a_commit_on_ss_rise: assert property (@(posedge clk) disable iff (!reset_n)
    (!$stable({enable_q, half_q, dead_q}) || fault_clear_q != '0) |-> $past(ss_rise));

endmodule

// File: hw/bridge_driver.sv
// drive sequencer for one full bridge, A / dead / B / dead while enabled
// one instance per bridge, its raw gate pattern goes through the fet guard
module bridge_driver (
  input  logic clk,
  input  logic reset_n,
  input  hbridge_pkg::bridge_cfg_t cfg,
  output hbridge_pkg::fets_t raw_fets
);

  typedef enum logic [2:0] {
    st_park,
    st_drive_a,
    st_dead_a,
    st_drive_b,
    st_dead_b
  } state_t;

  state_t state_q;
  // cycles left in the current phase, minus one
  logic [hbridge_pkg::half_w-1:0] cnt_q;
  logic [hbridge_pkg::half_w-1:0] half_load;
  logic [hbridge_pkg::half_w-1:0] dead_load;
  logic dead_skip;
  logic phase_done;

  // half of 0 runs as 1
  assign half_load = (cfg.half == '0) ? '0 : cfg.half - 1'b1;
  assign dead_load = hbridge_pkg::half_w'(cfg.dead) - 1'b1;
  // zero dead time goes straight across
  assign dead_skip = (cfg.dead == '0);
  assign phase_done = (cnt_q == '0);

  always_ff @(posedge clk)
  begin
    if (!reset_n || !cfg.enable)
    begin
      state_q <= st_park;
      cnt_q <= '0;
    end
    else if (state_q == st_park)
    begin
      state_q <= st_drive_a;
      cnt_q <= half_load;
    end
    else if (!phase_done)
    begin
      cnt_q <= cnt_q - 1'b1;
    end
    else
    begin
      // phase over, cfg is sampled here for the next one
      case (state_q)
        st_drive_a:
        begin
          state_q <= dead_skip ? st_drive_b : st_dead_a;
          cnt_q <= dead_skip ? half_load : dead_load;
        end
        st_dead_a:
        begin
          state_q <= st_drive_b;
          cnt_q <= half_load;
        end
        st_drive_b:
        begin
          state_q <= dead_skip ? st_drive_a : st_dead_b;
          cnt_q <= dead_skip ? half_load : dead_load;
        end
        default:
        begin
          state_q <= st_drive_a;
          cnt_q <= half_load;
        end
      endcase
    end
  end

  // park and both dead phases keep all four off
  always_comb
  begin
    case (state_q)
      st_drive_a: raw_fets = hbridge_pkg::fets_drive_a;
      st_drive_b: raw_fets = hbridge_pkg::fets_drive_b;
      default: raw_fets = '0;
    endcase
  end

  a_leg_exclusive: assert property (@(posedge clk) disable iff (!reset_n)
    !(raw_fets.f1 && raw_fets.f2) && !(raw_fets.f3 && raw_fets.f4));

  // a direct swap between drives only when the dead time was zero
  a_dead_between: assert property (@(posedge clk) disable iff (!reset_n)
    ((raw_fets == hbridge_pkg::fets_drive_b && $past(raw_fets) == hbridge_pkg::fets_drive_a) ||
     (raw_fets == hbridge_pkg::fets_drive_a && $past(raw_fets) == hbridge_pkg::fets_drive_b))
    |-> $past(cfg.dead) == '0);

endmodule

// File: hw/fet_guard.sv
// overcurrent fault latches and registered gate outputs for all bridges
// a latched fault holds that bridge off until the host clears it
module fet_guard (
  input  logic clk,
  input  logic reset_n,
  input  hbridge_pkg::fets_t raw_fets [hbridge_pkg::num_bridges],
  input  logic [hbridge_pkg::num_bridges-1:0] overcurrent,
  input  logic [hbridge_pkg::num_bridges-1:0] fault_clear,
  output hbridge_pkg::fets_t fets [hbridge_pkg::num_bridges],
  output logic [hbridge_pkg::num_bridges-1:0] fault
);

  // comparator inputs are asynchronous
  logic [hbridge_pkg::num_bridges-1:0] oc_meta_q;
  logic [hbridge_pkg::num_bridges-1:0] oc_sync_q;
  logic [hbridge_pkg::num_bridges-1:0] fault_q;

  always_ff @(posedge clk)
  begin
    if (!reset_n)
    begin
      oc_meta_q <= '0;
      oc_sync_q <= '0;
      fault_q <= '0;
    end
    else
    begin
      oc_meta_q <= overcurrent;
      oc_sync_q <= oc_meta_q;
      // set beats clear, so a clear with the pin still high does not hold
      fault_q <= oc_sync_q | (fault_q & ~fault_clear);
    end
  end

  assign fault = fault_q;

  // output flops, one cycle behind the drivers
  always_ff @(posedge clk)
  begin
    for (int b = 0; b < hbridge_pkg::num_bridges; b++)
    begin
      if (!reset_n || fault_q[b])
      begin
        fets[b] <= '0;
      end
      else
      begin
        fets[b] <= raw_fets[b];
      end
    end
  end

  for (genvar i = 0; i < hbridge_pkg::num_bridges; i++)
  begin : g_check
    // a fault seen this cycle means gates off on the next
    a_fault_blanks: assert property (@(posedge clk) disable iff (!reset_n)
      fault_q[i] |=> fets[i] == '0);
  end

endmodule

// File: hw/hbridge_top.sv
// four-bridge FET driver top, spi slave feeding the drivers through the guard
// single clk domain, spi pins are oversampled inside the slave
module hbridge_top (
  input  logic clk,
  input  logic reset_n,
  input  logic sck,
  input  logic ss_n,
  input  logic sdi,
  output logic sdo,
  input  logic [hbridge_pkg::num_bridges-1:0] overcurrent,
  output hbridge_pkg::fets_t fets [hbridge_pkg::num_bridges]
);

  hbridge_pkg::bridge_cfg_t cfg [hbridge_pkg::num_bridges];
  hbridge_pkg::fets_t raw_fets [hbridge_pkg::num_bridges];
  logic [hbridge_pkg::num_bridges-1:0] fault;
  logic [hbridge_pkg::num_bridges-1:0] fault_clear;

  spi_reg_slave slave_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .sck         (sck),
    .ss_n        (ss_n),
    .sdi         (sdi),
    .sdo         (sdo),
    .fault       (fault),
    .cfg         (cfg),
    .fault_clear (fault_clear)
  );

  // one sequencer per bridge
  for (genvar i = 0; i < hbridge_pkg::num_bridges; i++)
  begin : g_bridge
    bridge_driver driver_i (
      .clk      (clk),
      .reset_n  (reset_n),
      .cfg      (cfg[i]),
      .raw_fets (raw_fets[i])
    );
  end

  fet_guard guard_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .raw_fets    (raw_fets),
    .overcurrent (overcurrent),
    .fault_clear (fault_clear),
    .fets        (fets),
    .fault       (fault)
  );

endmodule

// File: dv/hbridge_tb.sv
// directed testbench for the four-bridge driver with an spi host model and per-feature tests
// runs as top module hbridge_tb and prints one line per test plus the totals
module hbridge_tb;
  timeunit 1ns;
  timeprecision 1ps;

  localparam int max_cycles = 20000;
  localparam hbridge_pkg::fets_t pat_a = 4'b1001;
  localparam hbridge_pkg::fets_t pat_b = 4'b0110;
  localparam hbridge_pkg::fets_t pat_off = 4'b0000;

  logic clk = 1'b0;
  logic reset_n = 1'b0;
  logic sck = 1'b0;
  logic ss_n = 1'b1;
  logic sdi = 1'b0;
  logic sdo;
  logic [hbridge_pkg::num_bridges-1:0] overcurrent = '0;
  hbridge_pkg::fets_t fets [hbridge_pkg::num_bridges];

  int seed = 32'h53a6;
  int n_checks = 0;
  int n_errors = 0;
  int t_checks = 0;
  int t_errors = 0;
  int leg_errors = 0;
  int cycle_count = 0;
  logic others_busy = 1'b0;

  hbridge_top dut_i (
    .clk         (clk),
    .reset_n     (reset_n),
    .sck         (sck),
    .ss_n        (ss_n),
    .sdi         (sdi),
    .sdo         (sdo),
    .overcurrent (overcurrent),
    .fets        (fets)
  );

  // 40 ns period
  always #20 clk = ~clk;

  // cycle limit well above the summed test lengths
  always @(posedge clk)
  begin
    cycle_count++;
    if (cycle_count >= max_cycles)
    begin
      $display("timeout: run still busy after %0d cycles", cycle_count);
      $display("CHECKS FAILED");
      $finish;
    end
  end

  // shoot-through watch on every bridge for the whole run
  always @(negedge clk)
  begin
    if (reset_n)
    begin
      for (int b = 0; b < hbridge_pkg::num_bridges; b++)
      begin
        assert (!(fets[b].f1 && fets[b].f2) && !(fets[b].f3 && fets[b].f4))
        else
        begin
          $display("leg overlap: both FETs of one leg on in bridge %0d", b);
          leg_errors++;
        end
      end
    end
  end

  function automatic int rand_range(input int lo, input int hi);
    int r;
    r = $random(seed) & 32'h7fff_ffff;
    return lo + r % (hi - lo + 1);
  endfunction

  task automatic check_eq(input string name, input int exp, input int act);
    n_checks++;
    t_checks++;
    assert (exp == act)
    else
    begin
      $display("ERROR %s: expected 0x%0h, actual 0x%0h", name, exp, act);
      n_errors++;
      t_errors++;
    end
  endtask

  task automatic check_true(input string name, input bit cond, input string what);
    n_checks++;
    t_checks++;
    assert (cond)
    else
    begin
      $display("ERROR %s: %s", name, what);
      n_errors++;
      t_errors++;
    end
  endtask

  task automatic start_test();
    t_checks = 0;
    t_errors = 0;
  endtask

  task automatic finish_test(input string name);
    if (t_errors == 0)
      $display("PASS  %s: %0d checks", name, t_checks);
    else
      $display("ERROR %s: %0d of %0d checks wrong", name, t_errors, t_checks);
  endtask

  // one 24-bit mode 0 frame with 4 clk per sck half period
  // returns right after ss goes high
  task automatic shift_frame(input hbridge_pkg::spi_frame_t frame, output logic [15:0] rdata);
    logic [hbridge_pkg::frame_w-1:0] rx;
    rx = '0;
    @(posedge clk);
    ss_n <= 1'b0;
    for (int i = hbridge_pkg::frame_w - 1; i >= 0; i--)
    begin
      // next bit goes out while sck is low
      sdi <= frame[i];
      repeat (3) @(posedge clk);
      // sdo moved after the last fall and has settled by now
      @(negedge clk);
      rx = {rx[hbridge_pkg::frame_w-2:0], sdo};
      @(posedge clk);
      sck <= 1'b1;
      repeat (4) @(posedge clk);
      sck <= 1'b0;
    end
    repeat (4) @(posedge clk);
    ss_n <= 1'b1;
    sdi <= 1'b0;
    rdata = rx[15:0];
  endtask

  task automatic spi_write(input logic [6:0] addr, input logic [15:0] data);
    hbridge_pkg::spi_frame_t f;
    logic [15:0] unused;
    f.rd = 1'b0;
    f.addr = addr;
    f.data = data;
    shift_frame(f, unused);
    // idle gap between frames
    repeat (8) @(posedge clk);
  endtask

  task automatic spi_read(input logic [6:0] addr, output logic [15:0] data);
    hbridge_pkg::spi_frame_t f;
    f.rd = 1'b1;
    f.addr = addr;
    f.data = '0;
    shift_frame(f, data);
    repeat (8) @(posedge clk);
  endtask

  // poll at negedges until the bridge shows pat or limit extra cycles pass
  task automatic wait_for_pattern(input int b, input hbridge_pkg::fets_t pat, input int limit,
                                  output bit ok);
    int n;
    n = 0;
    @(negedge clk);
    while (fets[b] != pat && n < limit)
    begin
      n++;
      @(negedge clk);
    end
    ok = (fets[b] == pat);
  endtask

  // cycles spent in pat from the current negedge on
  task automatic run_length(input int b, input hbridge_pkg::fets_t pat, output int len);
    len = 0;
    while (fets[b] == pat && len < 1000)
    begin
      for (int x = 0; x < hbridge_pkg::num_bridges; x++)
      begin
        if (x != b && fets[x] != pat_off)
          others_busy = 1'b1;
      end
      len++;
      @(negedge clk);
    end
  endtask

  // start of one drive A to the start of the next
  task automatic measure_period(input int b, output int p);
    int guard;
    guard = 0;
    @(negedge clk);
    while (fets[b] == pat_a && guard < 500)
    begin
      guard++;
      @(negedge clk);
    end
    while (fets[b] != pat_a && guard < 500)
    begin
      guard++;
      @(negedge clk);
    end
    p = 0;
    while (fets[b] == pat_a && p < 500)
    begin
      p++;
      @(negedge clk);
    end
    while (fets[b] != pat_a && p < 500)
    begin
      p++;
      @(negedge clk);
    end
  endtask

  task automatic stays_off(input int b, input int n, output bit quiet);
    quiet = 1'b1;
    repeat (n)
    begin
      @(negedge clk);
      if (fets[b] != pat_off)
        quiet = 1'b0;
    end
  endtask

  task automatic reset_readback();
    logic [15:0] rd;
    int h;
    start_test();
    @(negedge clk);
    for (int b = 0; b < hbridge_pkg::num_bridges; b++)
      check_eq("reset_readback", 0, int'(fets[b]));
    spi_read(7'd7, rd);
    check_eq("reset_readback", 32'h4842, int'(rd));
    spi_read(7'd6, rd);
    check_eq("reset_readback", 0, int'(rd));
    // half register of bridge 1
    h = rand_range(8, 40);
    spi_write(7'd2, 16'(h));
    spi_read(7'd2, rd);
    check_eq("reset_readback", h, int'(rd));
    // id is read-only
    spi_write(7'd7, 16'h1234);
    spi_read(7'd7, rd);
    check_eq("reset_readback", 32'h4842, int'(rd));
    finish_test("reset_readback");
  endtask

  task automatic drive_sequence();
    hbridge_pkg::spi_frame_t f;
    logic [15:0] unused;
    int h;
    int d;
    int len;
    bit ok;
    start_test();
    h = rand_range(8, 40);
    d = rand_range(1, 8);
    spi_write(7'd1, 16'(h));
    spi_write(7'd5, 16'(d));
    f.rd = 1'b0;
    f.addr = 7'd0;
    f.data = 16'h0001;
    shift_frame(f, unused);
    // switching starts within 7 cycles of ss rising
    wait_for_pattern(0, pat_a, 7, ok);
    check_true("drive_sequence", ok, "bridge 0 never entered drive A after enable");
    others_busy = 1'b0;
    run_length(0, pat_a, len);
    check_eq("drive_sequence", h, len);
    run_length(0, pat_off, len);
    check_eq("drive_sequence", d, len);
    run_length(0, pat_b, len);
    check_eq("drive_sequence", h, len);
    run_length(0, pat_off, len);
    check_eq("drive_sequence", d, len);
    // back to drive A for the next period
    check_eq("drive_sequence", int'(pat_a), int'(fets[0]));
    check_true("drive_sequence", !others_busy, "a disabled bridge switched its FETs");
    finish_test("drive_sequence");
  endtask

  task automatic independent_bridges();
    int halves [hbridge_pkg::num_bridges];
    int d;
    int p;
    int leg_before;
    bit dup;
    start_test();
    leg_before = leg_errors;
    for (int i = 0; i < hbridge_pkg::num_bridges; i++)
    begin
      dup = 1'b1;
      while (dup)
      begin
        halves[i] = rand_range(8, 40);
        dup = 1'b0;
        for (int j = 0; j < i; j++)
          if (halves[j] == halves[i])
            dup = 1'b1;
      end
      spi_write(7'd1 + 7'(i), 16'(halves[i]));
    end
    d = rand_range(1, 8);
    spi_write(7'd5, 16'(d));
    spi_write(7'd0, 16'h000f);
    for (int b = 0; b < hbridge_pkg::num_bridges; b++)
    begin
      measure_period(b, p);
      check_eq("independent_bridges", 2 * (halves[b] + d), p);
    end
    check_eq("independent_bridges", leg_before, leg_errors);
    finish_test("independent_bridges");
  endtask

  task automatic disable_parks();
    hbridge_pkg::spi_frame_t f;
    logic [15:0] rd;
    bit quiet;
    start_test();
    // drop bridge 1 while the others keep running
    f.rd = 1'b0;
    f.addr = 7'd0;
    f.data = 16'h000d;
    shift_frame(f, rd);
    // commit within 4 cycles plus park and the output flop
    repeat (7) @(negedge clk);
    check_eq("disable_parks", 0, int'(fets[1]));
    stays_off(1, 100, quiet);
    check_true("disable_parks", quiet, "bridge 1 switched again after its enable was cleared");
    spi_read(7'd6, rd);
    check_eq("disable_parks", (4'hd << 4) | 4'h0, int'(rd));
    finish_test("disable_parks");
  endtask

  task automatic overcurrent_fault();
    hbridge_pkg::spi_frame_t f;
    logic [15:0] rd;
    bit quiet;
    int n;
    start_test();
    // 3-cycle pulse on bridge 2
    @(posedge clk);
    overcurrent <= 4'b0100;
    for (int k = 1; k <= 4; k++)
    begin
      @(posedge clk);
      if (k == 3)
        overcurrent <= '0;
    end
    @(negedge clk);
    check_eq("overcurrent_fault", 0, int'(fets[2]));
    // latched with the pin low again
    spi_read(7'd6, rd);
    check_eq("overcurrent_fault", (4'hd << 4) | 4'h4, int'(rd));
    stays_off(2, 100, quiet);
    check_true("overcurrent_fault", quiet, "faulted bridge 2 switched while still enabled");
    f.rd = 1'b0;
    f.addr = 7'd6;
    f.data = 16'h0004;
    shift_frame(f, rd);
    // restart goes through park, so drive A comes first
    n = 0;
    @(negedge clk);
    while (fets[2] == pat_off && n < 20)
    begin
      n++;
      @(negedge clk);
    end
    check_eq("overcurrent_fault", int'(pat_a), int'(fets[2]));
    repeat (8) @(posedge clk);
    spi_read(7'd6, rd);
    check_eq("overcurrent_fault", (4'hd << 4) | 4'h0, int'(rd));
    finish_test("overcurrent_fault");
  endtask

  initial
  begin
    repeat (4) @(posedge clk);
    reset_n <= 1'b1;
    @(posedge clk);
    reset_readback();
    drive_sequence();
    independent_bridges();
    disable_parks();
    overcurrent_fault();
    $display("%0d checks, %0d errors, %0d leg overlaps", n_checks, n_errors, leg_errors);
    if (n_errors == 0 && leg_errors == 0)
      $display("ALL CHECKS PASSED");
    else
      $display("CHECKS FAILED");
    $finish;
  end

endmodule

// File: hbridge.f
hw/hbridge_pkg.sv
hw/spi_reg_slave.sv
hw/bridge_driver.sv
hw/fet_guard.sv
hw/hbridge_top.sv
dv/hbridge_tb.sv

// File: Makefile
VERILATOR ?= verilator
TB_TOP ?= hbridge_tb
RTL_TOP ?= hbridge_top
FILELIST ?= hbridge.f
BUILD_DIR ?= obj_dir
LOG ?= sim.log
TIMESCALE ?= 1ns/1ps
PASS_MSG ?= ALL CHECKS PASSED
VFLAGS ?= --binary --timing --assert --timescale $(TIMESCALE)
LINT_FLAGS ?= --lint-only -Wall --timing --timescale $(TIMESCALE)

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TB_TOP)

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TB_TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: build
	./$(SIM_BIN) | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
